// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile: obj_dir/mips_sim

obj_dir/mips_sim: build.f rtl/*.sv tb/*.sv
	verilator --binary --assert --timing -Wall -f build.f \
		--top-module mips_tb -o mips_sim --Mdir obj_dir

run: compile
	./obj_dir/mips_sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
rtl/mips_pkg.sv
rtl/mips_control.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_next_pc.sv
rtl/mips_cpu_harvard.sv
tb/mips_cpu_checker.sv
tb/mips_tb.sv

// ==== rtl/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
  input  mips_pkg::ctrl_t ctrl,
  input  mips_pkg::word_t rs_data,
  input  mips_pkg::word_t rt_data,
  input  logic [15:0]     imm,
  input  logic [4:0]      shamt,
  output mips_pkg::word_t result,
  output logic            equal
);

  mips_pkg::word_t imm_ext;
  mips_pkg::word_t operand_b;
  logic [4:0]      shift_amount;

  // Logic immediates are zero-extended, the rest sign-extended
  assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign operand_b = ctrl.alu_src_imm ? imm_ext : rt_data;

  // Variable shifts would take rs; kept shifts all use shamt
  assign shift_amount = ctrl.shift_by_shamt ? shamt : rs_data[4:0];

  always_comb
  begin
    case (ctrl.alu_op)
      mips_pkg::alu_add:  result = rs_data + operand_b;
      mips_pkg::alu_sub:  result = rs_data - operand_b;
      mips_pkg::alu_and:  result = rs_data & operand_b;
      mips_pkg::alu_or:   result = rs_data | operand_b;
      mips_pkg::alu_xor:  result = rs_data ^ operand_b;
      mips_pkg::alu_nor:  result = ~(rs_data | operand_b);
      // Compares give 0 or 1
      mips_pkg::alu_slt:
      begin
        result = {31'd0, $signed(rs_data) < $signed(operand_b)};
      end
      mips_pkg::alu_sltu:
      begin
        result = {31'd0, rs_data < operand_b};
      end
      // Shifts act on rt
      mips_pkg::alu_sll:  result = operand_b << shift_amount;
      mips_pkg::alu_srl:  result = operand_b >> shift_amount;
      mips_pkg::alu_sra:
      begin
        result = mips_pkg::word_t'($signed(operand_b) >>> shift_amount);
      end
      // Immediate into the upper half
      mips_pkg::alu_lui:  result = {operand_b[15:0], 16'h0000};
      default:            result = '0;
    endcase
  end

  // Branch compare, always on the two register operands
  assign equal = (rs_data == rt_data);

endmodule

`default_nettype wire

// ==== rtl/mips_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_control (
  input  mips_pkg::opcode_t opcode,
  input  mips_pkg::funct_t  funct,
  output mips_pkg::ctrl_t   ctrl
);

  always_comb
  begin
    // Cleared word is a NOP: no writes, no memory access, sequential PC
    ctrl = '0;
    case (opcode)
      // SPECIAL group, operation comes from funct
      6'h00:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = mips_pkg::dst_rd;
        case (funct)
          // ADDU, SUBU
          6'h21: ctrl.alu_op = mips_pkg::alu_add;
          6'h23: ctrl.alu_op = mips_pkg::alu_sub;
          // Bitwise logic
          6'h24: ctrl.alu_op = mips_pkg::alu_and;
          6'h25: ctrl.alu_op = mips_pkg::alu_or;
          6'h26: ctrl.alu_op = mips_pkg::alu_xor;
          // Signed and unsigned compare
          6'h2a: ctrl.alu_op = mips_pkg::alu_slt;
          6'h2b: ctrl.alu_op = mips_pkg::alu_sltu;
          // Constant shifts, amount from the shamt field
          6'h00:
          begin
            ctrl.alu_op         = mips_pkg::alu_sll;
            ctrl.shift_by_shamt = 1'b1;
          end
          6'h02:
          begin
            ctrl.alu_op         = mips_pkg::alu_srl;
            ctrl.shift_by_shamt = 1'b1;
          end
          6'h03:
          begin
            ctrl.alu_op         = mips_pkg::alu_sra;
            ctrl.shift_by_shamt = 1'b1;
          end
          // JR, no register result
          6'h08:
          begin
            ctrl.reg_write = 1'b0;
            ctrl.pc_sel    = mips_pkg::pc_jr;
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      // J and JAL; JAL links PC+8 into ra
      6'h02: ctrl.pc_sel = mips_pkg::pc_jump;
      6'h03:
      begin
        ctrl.pc_sel    = mips_pkg::pc_jump;
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = mips_pkg::dst_ra;
        ctrl.wb_sel    = mips_pkg::wb_pc8;
      end
      // BEQ, BNE
      6'h04: ctrl.pc_sel = mips_pkg::pc_beq;
      6'h05: ctrl.pc_sel = mips_pkg::pc_bne;
      // ADDIU, SLTIU with sign-extended immediate
      6'h09,
      6'h0b:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = (opcode == 6'h09) ? mips_pkg::alu_add : mips_pkg::alu_sltu;
      end
      // ANDI, ORI, XORI zero-extend
      6'h0c,
      6'h0d,
      6'h0e:
      begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        case (opcode[1:0])
          2'b00:   ctrl.alu_op = mips_pkg::alu_and;
          2'b01:   ctrl.alu_op = mips_pkg::alu_or;
          default: ctrl.alu_op = mips_pkg::alu_xor;
        endcase
      end
      // LUI
      6'h0f:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = mips_pkg::alu_lui;
      end
      // LW, address is base plus offset
      6'h23:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb_sel      = mips_pkg::wb_mem;
      end
      // SW
      6'h2b:
      begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mips_cpu_harvard.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard (
  input  logic            clk,
  input  logic            reset,
  output logic            active,
  output mips_pkg::word_t register_v0,

  input  logic            clk_enable,

  // Instruction port, combinational read
  output mips_pkg::word_t instr_address,
  input  mips_pkg::word_t instr_readdata,

  // Data port, combinational read and write at the edge
  output mips_pkg::word_t data_address,
  output logic            data_write,
  output logic            data_read,
  output mips_pkg::word_t data_writedata,
  input  mips_pkg::word_t data_readdata
);

  mips_pkg::ctrl_t     ctrl;
  mips_pkg::opcode_t   opcode;
  mips_pkg::funct_t    funct;
  mips_pkg::reg_addr_t rs_addr;
  mips_pkg::reg_addr_t rt_addr;
  mips_pkg::reg_addr_t rd_addr;
  mips_pkg::reg_addr_t wr_addr;
  logic [4:0]          shamt;
  logic [15:0]         imm;
  logic [25:0]         instr_index;
  mips_pkg::word_t     rs_data;
  mips_pkg::word_t     rt_data;
  mips_pkg::word_t     alu_result;
  mips_pkg::word_t     pc_plus8;
  mips_pkg::word_t     wr_data;
  logic                equal;
  logic                go;

  // Instruction fields
  assign opcode      = instr_readdata[31:26];
  assign rs_addr     = instr_readdata[25:21];
  assign rt_addr     = instr_readdata[20:16];
  assign rd_addr     = instr_readdata[15:11];
  assign shamt       = instr_readdata[10:6];
  assign funct       = instr_readdata[5:0];
  assign imm         = instr_readdata[15:0];
  assign instr_index = instr_readdata[25:0];

  mips_control i_control (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  // Destination field
  always_comb
  begin
    case (ctrl.dst_sel)
      mips_pkg::dst_rd: wr_addr = rd_addr;
      mips_pkg::dst_ra: wr_addr = mips_pkg::reg_ra;
      default:          wr_addr = rt_addr;
    endcase
  end

  // Writeback source
  always_comb
  begin
    case (ctrl.wb_sel)
      mips_pkg::wb_mem: wr_data = data_readdata;
      mips_pkg::wb_pc8: wr_data = pc_plus8;
      default:          wr_data = alu_result;
    endcase
  end

  mips_regfile i_regfile (
    .clk     (clk),
    .reset   (reset),
    .enable  (clk_enable),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .wr_addr (wr_addr),
    .wr_en   (ctrl.reg_write && active),
    .wr_data (wr_data),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .v0      (register_v0)
  );

  mips_alu i_alu (
    .ctrl    (ctrl),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .imm     (imm),
    .shamt   (shamt),
    .result  (alu_result),
    .equal   (equal)
  );

  mips_next_pc i_next_pc (
    .clk         (clk),
    .reset       (reset),
    .enable      (clk_enable),
    .ctrl        (ctrl),
    .equal       (equal),
    .rs_data     (rs_data),
    .instr_index (instr_index),
    .imm         (imm),
    .pc          (instr_address),
    .pc_plus8    (pc_plus8),
    .active      (active)
  );

  // Memory strobes only in a running, enabled cycle
  assign go             = active && clk_enable;
  assign data_read      = ctrl.mem_read && go;
  assign data_write     = ctrl.mem_write && go;
  assign data_address   = alu_result;
  assign data_writedata = rt_data;

endmodule

`default_nettype wire

// ==== rtl/mips_next_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_next_pc (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  mips_pkg::ctrl_t ctrl,
  input  logic            equal,
  input  mips_pkg::word_t rs_data,
  input  logic [25:0]     instr_index,
  input  logic [15:0]     imm,
  output mips_pkg::word_t pc,
  output mips_pkg::word_t pc_plus8,
  output logic            active
);

  mips_pkg::word_t pc_plus4;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  mips_pkg::word_t target;
  mips_pkg::word_t pending_target;
  logic            pending;
  logic            taken;
  logic            step;

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;

  // Offset counts words relative to the delay slot
  assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
  // Region of the delay slot
  assign jump_target = {pc_plus4[31:28], instr_index, 2'b00};

  assign step = enable && active;

  always_comb
  begin
    taken  = 1'b0;
    target = branch_target;
    case (ctrl.pc_sel)
      mips_pkg::pc_beq:  taken = equal;
      mips_pkg::pc_bne:  taken = !equal;
      mips_pkg::pc_jump:
      begin
        taken  = 1'b1;
        target = jump_target;
      end
      mips_pkg::pc_jr:
      begin
        taken  = 1'b1;
        target = rs_data;
      end
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc      <= mips_pkg::reset_vector;
      pending <= 1'b0;
      active  <= 1'b0;
    end
    else if (!active)
    begin
      // Leaving reset starts the core; after halt the PC sits at 0
      active <= (pc != '0);
    end
    else if (enable)
    begin
      if (pc == '0)
      begin
        active <= 1'b0;
      end
      else
      begin
        // Delay slot goes first, the redirect lands one edge later
        pc      <= pending ? pending_target : pc_plus4;
        pending <= taken;
      end
    end
  end

  // Target held for the instruction after the delay slot
  always_ff @(posedge clk)
  begin
    if (step && taken)
    begin
      pending_target <= target;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  // Datapath word and instruction field widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // First fetch address, kseg1 boot ROM
  localparam word_t reset_vector = 32'hbfc0_0000;

  // Register indices with a fixed role
  localparam reg_addr_t reg_v0 = 5'd2;
  localparam reg_addr_t reg_ra = 5'd31;

  // ALU operations; zero is ADD so a cleared control word is harmless
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_nor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_lui
  } alu_op_t;

  // Writeback source
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_pc8
  } wb_sel_t;

  // Destination register field
  typedef enum logic [1:0] {
    dst_rt,
    dst_rd,
    dst_ra
  } dst_sel_t;

  // Control flow kind
  typedef enum logic [2:0] {
    pc_seq,
    pc_beq,
    pc_bne,
    pc_jump,
    pc_jr
  } pc_sel_t;

  // Decoded controls for one instruction
  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    alu_op_t  alu_op;
    logic     alu_src_imm;
    logic     imm_zero_ext;
    logic     shift_by_shamt;
    wb_sel_t  wb_sel;
    dst_sel_t dst_sel;
    pc_sel_t  pc_sel;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  mips_pkg::reg_addr_t rs_addr,
  input  mips_pkg::reg_addr_t rt_addr,
  input  mips_pkg::reg_addr_t wr_addr,
  input  logic                wr_en,
  input  mips_pkg::word_t     wr_data,
  output mips_pkg::word_t     rs_data,
  output mips_pkg::word_t     rt_data,
  output mips_pkg::word_t     v0
);

  mips_pkg::word_t regs [0:31];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    // r0 is never written, so it reads zero forever
    else if (enable && wr_en && (wr_addr != '0))
    begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Asynchronous read ports
  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  // Debug tap on v0
  assign v0 = regs[mips_pkg::reg_v0];

endmodule

`default_nettype wire

// ==== tb/mips_cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_checker (
  input logic            clk,
  input logic            reset,
  input logic            clk_enable,
  input logic            active,
  input mips_pkg::word_t instr_address,
  input logic            data_read,
  input logic            data_write
);

  // One data access per cycle at most
  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(data_read && data_write))
    else $error("data_read and data_write high together");

  // Fetch address stays on a word boundary
  fetch_aligned: assert property (@(posedge clk) disable iff (reset)
    instr_address[1:0] == 2'b00)
    else $error("instr_address not word aligned: %h", instr_address);

  // Stalled or halted core leaves memory alone
  strobes_gated: assert property (@(posedge clk) disable iff (reset)
    (!clk_enable || !active) |-> (!data_read && !data_write))
    else $error("memory strobe while stalled or halted");

  // Core starts on the edge after reset drops
  starts_after_reset: assert property (@(posedge clk)
    $fell(reset) |=> active)
    else $error("active not set one cycle after reset");

endmodule

bind mips_cpu_harvard mips_cpu_checker i_checker (
  .clk           (clk),
  .reset         (reset),
  .clk_enable    (clk_enable),
  .active        (active),
  .instr_address (instr_address),
  .data_read     (data_read),
  .data_write    (data_write)
);

`default_nettype wire

// ==== tb/mips_stim.mem ====
// Program word count, program words, store count, (address data) pairs,
// then the expected final register_v0; all hex
00000028
3c011234 34215678 ac010000 2402fffd
ac020004 00221821 ac030008 00222023
ac04000c 00222826 00023043 ac050010
ac060014 0041382a 0041402b 00014902
00015200 ac070018 ac08001c ac090020
ac0a0024 8c0b0000 ac0b0028 102b0002
ac09002c ac010030 142b0005 ac030030
0ff00022 302cff00 ac1f0034 0bf00025
ac0c003c 24020063 398d00ff 03e00008
ac0d0038 24420010 00000008 ac020040
// Expected stores
00000011
00000000 12345678
00000004 fffffffd
00000008 12345675
0000000c 1234567b
00000010 edcba985
00000014 fffffffe
00000018 00000001
0000001c 00000000
00000020 01234567
00000024 34567800
00000028 12345678
0000002c 01234567
00000030 12345675
00000038 000056ff
00000034 bfc00078
0000003c 00005600
00000040 0000000d
// Final v0
0000000d

// ==== tb/mips_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_tb;

  logic            clk;
  logic            reset;
  logic            clk_enable;
  logic            active;
  logic            data_write;
  logic            data_read;
  mips_pkg::word_t register_v0;
  mips_pkg::word_t instr_address;
  mips_pkg::word_t instr_readdata;
  mips_pkg::word_t data_address;
  mips_pkg::word_t data_writedata;
  mips_pkg::word_t data_readdata;

  // Raw stim image and the tables parsed from it
  logic [31:0]     stim [0:511];
  mips_pkg::word_t imem [0:255];
  mips_pkg::word_t dmem [0:255];
  mips_pkg::word_t exp_addr [0:63];
  mips_pkg::word_t exp_data [0:63];
  mips_pkg::word_t exp_v0;
  int              prog_len;
  int              store_count;
  int              store_idx;
  int              errors;
  int              checks;
  bit              limit_ready;
  longint          limit_ns;

  mips_cpu_harvard i_mips_cpu_harvard (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Boot ROM window at 0xBFC00000, NOPs elsewhere
  always_comb
  begin
    if ((instr_address & 32'hffff_fc00) == 32'hbfc0_0000)
      instr_readdata = imem[instr_address[9:2]];
    else
      instr_readdata = '0;
  end

  // Data RAM in the lowest 1 KiB, read data only while a load strobes
  always_comb
  begin
    if (data_read && (data_address[31:10] == '0))
      data_readdata = dmem[data_address[9:2]];
    else
      data_readdata = '0;
  end

  always @(posedge clk)
  begin
    if (data_write)
    begin
      if (data_address[31:10] == '0)
        dmem[data_address[9:2]] <= data_writedata;
      check_store(data_address, data_writedata);
    end
  end

  // Stores must follow the expected list in order
  task automatic check_store(input mips_pkg::word_t addr, input mips_pkg::word_t data);
    if (store_idx >= store_count)
    begin
      errors++;
      $display("Unexpected store to address %h after the last expected one", addr);
    end
    else
    begin
      checks++;
      if (addr != exp_addr[store_idx])
      begin
        errors++;
        $display("** Error data_address: expected %h got %h", exp_addr[store_idx], addr);
      end
      if (data != exp_data[store_idx])
      begin
        errors++;
        $display("** Error data_writedata: expected %h got %h", exp_data[store_idx], data);
      end
      store_idx++;
    end
  endtask

  task automatic load_stim;
    int base;
    $readmemh("tb/mips_stim.mem", stim);
    prog_len = stim[0];
    for (int i = 0; i < 256; i++)
      imem[i] = (i < prog_len) ? stim[1 + i] : '0;
    store_count = stim[prog_len + 1];
    base = prog_len + 2;
    for (int k = 0; k < store_count; k++)
    begin
      exp_addr[k] = stim[base + 2 * k];
      exp_data[k] = stim[base + 2 * k + 1];
    end
    exp_v0 = stim[base + 2 * store_count];
  endtask

  // Every word gets a value of its own address
  task automatic fill_data_memory;
    for (int i = 0; i < 256; i++)
      dmem[i] = 32'hd000_0000 | (i * 4);
  endtask

  task automatic run_pass(input bit stall);
    reset      = 1'b1;
    clk_enable = 1'b1;
    fill_data_memory();
    store_idx = 0;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    @(posedge clk);
    #1;
    if (active !== 1'b1)
    begin
      errors++;
      $display("** Error active: expected 1 got %h", active);
    end
    if (instr_address !== 32'hbfc0_0000)
    begin
      errors++;
      $display("** Error instr_address: expected %h got %h",
               32'hbfc0_0000, instr_address);
    end
    if (data_read !== 1'b0 || data_write !== 1'b0)
    begin
      errors++;
      $display("** Error data_read/data_write: expected 0/0 got %h/%h",
               data_read, data_write);
    end
    // Run until halt, stalls drawn per cycle in pass 2
    while (active)
    begin
      @(posedge clk);
      #1;
      if (stall)
        clk_enable = ($urandom % 4) != 0;
    end
    clk_enable = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    if (active)
    begin
      errors++;
      $display("CPU became active again after halting");
    end
    if (store_idx != store_count)
    begin
      errors++;
      $display("** Error store count: expected %h got %h", store_count, store_idx);
    end
    if (register_v0 !== exp_v0)
    begin
      errors++;
      $display("** Error register_v0: expected %h got %h", exp_v0, register_v0);
    end
  endtask

  // Watchdog sized from the program length
  initial
  begin
    wait (limit_ready);
    #(limit_ns);
    $display("Timeout: CPU did not halt within %0d ns", limit_ns);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    reset       = 1'b1;
    clk_enable  = 1'b0;
    errors      = 0;
    checks      = 0;
    limit_ready = 1'b0;
    void'($urandom(32'h81d9_85e0));
    load_stim();
    limit_ns    = 2 * (16 + 8 + prog_len * 4) * 10;
    limit_ready = 1'b1;
    run_pass(1'b0);
    run_pass(1'b1);
    $display("Store checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
